/* Bender.yml */
package:
  name: pcie_al_bridge

sources:
  # RTL in compile order
  - files:
      - design/pcie_al_pkg.sv
      - design/tlp_rx_parser.sv
      - design/al_rd_issue.sv
      - design/cpl_tx_packer.sv
      - design/pcie_al_bridge.sv

  # Testbench
  - target: test
    include_dirs:
      - tb
    files:
      - tb/bridge_tb.sv

/* design/al_rd_issue.sv */
// AL read request generator issuing one burst of word reads per completion
`timescale 1ns/100ps

module al_rd_issue import pcie_al_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              rd_start,
    input  logic [ADDR_W-1:2] start_addr,
    input  logic [LEN_W-1:0]  start_len,

    output logic [ADDR_W-1:2] al_araddr,
    output logic              al_arvalid,
    input  logic              al_arready
);

    logic [LEN_W-1:0] remaining;
    logic             ar_fire;

    assign ar_fire = al_arvalid && al_arready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remaining  <= '0;
            al_arvalid <= 1'b0;
        end else begin
            if (rd_start) begin
                remaining  <= start_len;
                al_arvalid <= (start_len != '0);
            end else if (ar_fire) begin
                remaining  <= remaining - 1'b1;
                // Drop after the last accepted request
                al_arvalid <= (remaining != 1);
            end
        end
    end

    // Word address walks up by one per accepted request
    always_ff @(posedge clk) begin
        if (rd_start) begin
            al_araddr <= start_addr;
        end else if (ar_fire) begin
            al_araddr <= al_araddr + 1'b1;
        end
    end

endmodule

/* design/cpl_tx_packer.sv */
// Completion builder framing the CplD header and packing AL read data into beats
`timescale 1ns/100ps

module cpl_tx_packer import pcie_al_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [15:0]       cfg_completer_id,

    input  rd_req_t           rd_req,
    input  logic              rd_req_valid,
    output logic              rd_done,

    output logic              rd_start,
    output logic [ADDR_W-1:2] start_addr,
    output logic [LEN_W-1:0]  start_len,

    input  logic [AL_DW-1:0]  al_rdata,
    input  logic              al_rvalid,
    output logic              al_rready,

    output logic [AXIS_W-1:0] tx_tdata,
    output logic [KEEP_W-1:0] tx_tkeep,
    output logic              tx_tlast,
    output logic              tx_tvalid,
    input  logic              tx_tready
);

    cpl_state_t       state;
    logic [LEN_W-1:0] words_left;
    logic [AL_DW-1:0] hdr_dw0;
    logic [AL_DW-1:0] hdr_dw1;
    logic [AL_DW-1:0] hdr_dw2;
    logic             beat_free;
    logic             rd_fire;
    logic             last_word;

    assign beat_free = !tx_tvalid || tx_tready;
    assign al_rready = beat_free;
    assign rd_fire   = al_rvalid && al_rready;
    assign last_word = (words_left == 1);

    // rd_done still high means the held request was just served
    assign rd_start   = (state == CPL_IDLE) && rd_req_valid && !rd_done && beat_free;
    assign start_addr = rd_req.addr;
    assign start_len  = rd_req.len;

    assign hdr_dw0 = {1'b0, CPL_DATA, 1'b0, rd_req.tc, 4'b0000, 1'b0, 1'b0,
                      rd_req.attr, 2'b00, 2'b00, rd_req.len};
    // Byte count is four bytes per dword
    assign hdr_dw1 = {cfg_completer_id, CPL_STATUS_SC, 1'b0, 2'b00, rd_req.len, 2'b00};
    assign hdr_dw2 = {rd_req.req_id, rd_req.tag, 1'b0, rd_req.addr[6:2], 2'b00};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= CPL_IDLE;
            words_left <= '0;
            tx_tvalid  <= 1'b0;
            rd_done    <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            if (tx_tvalid && tx_tready) begin
                tx_tvalid <= 1'b0;
            end

            case (state)
                CPL_IDLE: begin
                    if (rd_start) begin
                        tx_tvalid  <= 1'b1;
                        words_left <= rd_req.len;
                        state      <= CPL_HDR2;
                    end
                end
                CPL_HDR2, CPL_DW1: begin
                    if (rd_fire) begin
                        tx_tvalid  <= 1'b1;
                        words_left <= words_left - 1'b1;
                        rd_done    <= last_word;
                        state      <= last_word ? CPL_IDLE : CPL_DW0;
                    end
                end
                CPL_DW0: begin
                    if (rd_fire) begin
                        words_left <= words_left - 1'b1;
                        if (last_word) begin
                            tx_tvalid <= 1'b1;
                            rd_done   <= 1'b1;
                            state     <= CPL_IDLE;
                        end else begin
                            state <= CPL_DW1;
                        end
                    end
                end
                default: state <= CPL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            CPL_IDLE: begin
                if (rd_start) begin
                    tx_tdata <= {hdr_dw1, hdr_dw0};
                    tx_tkeep <= 2'b11;
                    tx_tlast <= 1'b0;
                end
            end
            CPL_HDR2: begin
                // DW2 low, first read word high
                if (rd_fire) begin
                    tx_tdata <= {al_rdata, hdr_dw2};
                    tx_tkeep <= 2'b11;
                    tx_tlast <= last_word;
                end
            end
            CPL_DW0: begin
                if (rd_fire) begin
                    tx_tdata[AL_DW-1:0] <= al_rdata;
                    tx_tkeep            <= 2'b01;
                    tx_tlast            <= last_word;
                end
            end
            CPL_DW1: begin
                if (rd_fire) begin
                    tx_tdata[AXIS_W-1:AL_DW] <= al_rdata;
                    tx_tkeep                 <= 2'b11;
                    tx_tlast                 <= last_word;
                end
            end
            default: ;
        endcase
    end

endmodule

/* design/pcie_al_bridge.sv */
// PCIe endpoint stream to AL register bus bridge, 7-series 64-bit data path
`timescale 1ns/100ps

module pcie_al_bridge import pcie_al_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [15:0]       cfg_completer_id,

    input  logic [AXIS_W-1:0] rx_tdata,
    input  logic [KEEP_W-1:0] rx_tkeep,
    input  logic              rx_tlast,
    input  logic              rx_tvalid,
    output logic              rx_tready,

    output logic [AXIS_W-1:0] tx_tdata,
    output logic [KEEP_W-1:0] tx_tkeep,
    output logic              tx_tlast,
    output logic              tx_tvalid,
    input  logic              tx_tready,

    output al_wr_t            al_wr,
    output logic              al_wvalid,
    input  logic              al_wready,

    output logic [ADDR_W-1:2] al_araddr,
    output logic              al_arvalid,
    input  logic              al_arready,

    input  logic [AL_DW-1:0]  al_rdata,
    input  logic              al_rvalid,
    output logic              al_rready
);

    rd_req_t           rd_req;
    logic              rd_req_valid;
    logic              rd_done;
    logic              rd_start;
    logic [ADDR_W-1:2] start_addr;
    logic [LEN_W-1:0]  start_len;

    tlp_rx_parser u_rx_parser (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_tdata     (rx_tdata),
        .rx_tkeep     (rx_tkeep),
        .rx_tlast     (rx_tlast),
        .rx_tvalid    (rx_tvalid),
        .rx_tready    (rx_tready),
        .al_wr        (al_wr),
        .al_wvalid    (al_wvalid),
        .al_wready    (al_wready),
        .rd_req       (rd_req),
        .rd_req_valid (rd_req_valid),
        .rd_done      (rd_done)
    );

    al_rd_issue u_rd_issue (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_start   (rd_start),
        .start_addr (start_addr),
        .start_len  (start_len),
        .al_araddr  (al_araddr),
        .al_arvalid (al_arvalid),
        .al_arready (al_arready)
    );

    cpl_tx_packer u_cpl_packer (
        .clk              (clk),
        .rst_n            (rst_n),
        .cfg_completer_id (cfg_completer_id),
        .rd_req           (rd_req),
        .rd_req_valid     (rd_req_valid),
        .rd_done          (rd_done),
        .rd_start         (rd_start),
        .start_addr       (start_addr),
        .start_len        (start_len),
        .al_rdata         (al_rdata),
        .al_rvalid        (al_rvalid),
        .al_rready        (al_rready),
        .tx_tdata         (tx_tdata),
        .tx_tkeep         (tx_tkeep),
        .tx_tlast         (tx_tlast),
        .tx_tvalid        (tx_tvalid),
        .tx_tready        (tx_tready)
    );

endmodule

/* design/pcie_al_pkg.sv */
// PCIe to AL bridge shared widths, TLP codes, state encodings and payload types
package pcie_al_pkg;

    // Stream and bus widths
    localparam int AXIS_W = 64;
    localparam int KEEP_W = 2;
    localparam int ADDR_W = 10;
    localparam int LEN_W  = 8;
    localparam int AL_DW  = 32;

    // 7-series fmt/type codes, 3DW header only
    typedef enum logic [6:0] {
        MEM_RD32 = 7'b00_00000,
        MEM_WR32 = 7'b10_00000,
        CPL_DATA = 7'b10_01010
    } fmt_type_t;

    typedef enum logic [1:0] {
        KIND_MEM_RD,
        KIND_MEM_WR,
        KIND_UNSUPPORTED
    } tlp_kind_t;

    localparam logic [2:0] CPL_STATUS_SC = 3'b000;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_SKIP,
        RX_HDR2_WR,
        RX_HDR2_RD,
        RX_DW0,
        RX_DW1
    } rx_state_t;

    typedef enum logic [1:0] {
        CPL_IDLE,
        CPL_HDR2,
        CPL_DW0,
        CPL_DW1
    } cpl_state_t;

    // Header beat 0 as seen on the 7-series stream, DW0 in the low half
    typedef struct packed {
        logic [15:0] req_id;
        logic [7:0]  tag;
        logic [3:0]  last_be;
        logic [3:0]  first_be;
        logic        rsvd0;
        logic [6:0]  fmt_type;
        logic        rsvd1;
        logic [2:0]  tc;
        logic [3:0]  rsvd2;
        logic        td;
        logic        ep;
        logic [1:0]  attr;
        logic [1:0]  at;
        logic [9:0]  length;
    } tlp_hdr0_t;

    typedef struct packed {
        logic [15:0]       req_id;
        logic [7:0]        tag;
        logic [2:0]        tc;
        logic [1:0]        attr;
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:2] addr;
    } rd_req_t;

    typedef struct packed {
        logic [ADDR_W-1:2] addr;
        logic [AL_DW-1:0]  data;
    } al_wr_t;

endpackage

/* design/tlp_rx_parser.sv */
// Receive TLP parser turning MemWr32 into AL writes and capturing MemRd32 requests
`timescale 1ns/100ps

module tlp_rx_parser import pcie_al_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    input  logic [AXIS_W-1:0] rx_tdata,
    input  logic [KEEP_W-1:0] rx_tkeep,
    input  logic              rx_tlast,
    input  logic              rx_tvalid,
    output logic              rx_tready,

    output al_wr_t            al_wr,
    output logic              al_wvalid,
    input  logic              al_wready,

    output rd_req_t           rd_req,
    output logic              rd_req_valid,
    input  logic              rd_done
);

    rx_state_t state;
    tlp_hdr0_t hdr;
    tlp_kind_t kind;
    logic      intake_en;
    logic      hdr_usable;
    logic      wr_free;
    logic      last_dw;
    logic      rx_fire;
    logic      dw_step;

    assign hdr = rx_tdata;

    always_comb begin
        if (hdr.fmt_type == MEM_RD32) begin
            kind = KIND_MEM_RD;
        end else if (hdr.fmt_type == MEM_WR32) begin
            kind = KIND_MEM_WR;
        end else begin
            kind = KIND_UNSUPPORTED;
        end
    end

    // Only full first dword, not poisoned
    assign hdr_usable = !hdr.ep && (hdr.first_be == 4'hf);
    assign wr_free    = !al_wvalid || al_wready;
    assign last_dw    = (state == RX_DW1) || (rx_tlast && !rx_tkeep[1]);

    always_comb begin
        case (state)
            RX_IDLE:                         rx_tready = intake_en && wr_free && !rd_req_valid;
            RX_SKIP, RX_HDR2_WR, RX_HDR2_RD: rx_tready = 1'b1;
            RX_DW0, RX_DW1:                  rx_tready = last_dw && wr_free;
            default:                         rx_tready = 1'b0;
        endcase
    end

    assign rx_fire = rx_tvalid && rx_tready;
    // One dword of the held beat goes out per cycle
    assign dw_step = rx_tvalid && wr_free;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= RX_IDLE;
            intake_en    <= 1'b0;
            al_wvalid    <= 1'b0;
            rd_req_valid <= 1'b0;
        end else begin
            intake_en <= 1'b1;
            if (al_wvalid && al_wready) begin
                al_wvalid <= 1'b0;
            end
            if (rd_done) begin
                rd_req_valid <= 1'b0;
            end

            case (state)
                RX_IDLE: begin
                    if (rx_fire) begin
                        if (!hdr_usable || kind == KIND_UNSUPPORTED) begin
                            state <= rx_tlast ? RX_IDLE : RX_SKIP;
                        end else if (kind == KIND_MEM_WR) begin
                            state <= RX_HDR2_WR;
                        end else begin
                            state <= RX_HDR2_RD;
                        end
                    end
                end
                RX_SKIP: begin
                    if (rx_fire && rx_tlast) begin
                        state <= RX_IDLE;
                    end
                end
                RX_HDR2_WR: begin
                    // DW3 is the first payload dword
                    if (rx_fire) begin
                        al_wvalid <= 1'b1;
                        state     <= rx_tlast ? RX_IDLE : RX_DW0;
                    end
                end
                RX_HDR2_RD: begin
                    if (rx_fire) begin
                        rd_req_valid <= 1'b1;
                        state        <= rx_tlast ? RX_IDLE : RX_SKIP;
                    end
                end
                RX_DW0, RX_DW1: begin
                    if (dw_step) begin
                        al_wvalid <= 1'b1;
                        if (last_dw) begin
                            state <= rx_tlast ? RX_IDLE : RX_DW0;
                        end else begin
                            state <= RX_DW1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            RX_IDLE: begin
                if (rx_fire && kind == KIND_MEM_RD) begin
                    rd_req.req_id <= hdr.req_id;
                    rd_req.tag    <= hdr.tag;
                    rd_req.tc     <= hdr.tc;
                    rd_req.attr   <= hdr.attr;
                    rd_req.len    <= hdr.length[LEN_W-1:0];
                end
            end
            RX_HDR2_WR: begin
                if (rx_fire) begin
                    al_wr.addr <= rx_tdata[ADDR_W-1:2];
                    al_wr.data <= rx_tdata[AXIS_W-1:AL_DW];
                end
            end
            RX_HDR2_RD: begin
                if (rx_fire) begin
                    rd_req.addr <= rx_tdata[ADDR_W-1:2];
                end
            end
            RX_DW0, RX_DW1: begin
                if (dw_step) begin
                    al_wr.addr <= al_wr.addr + 1'b1;
                    al_wr.data <= (state == RX_DW0) ? rx_tdata[AL_DW-1:0]
                                                    : rx_tdata[AXIS_W-1:AL_DW];
                end
            end
            default: ;
        endcase
    end

endmodule

/* files.f */
+incdir+tb
design/pcie_al_pkg.sv
design/tlp_rx_parser.sv
design/al_rd_issue.sv
design/cpl_tx_packer.sv
design/pcie_al_bridge.sv
tb/bridge_tb.sv

/* tb/bridge_tb_tlp.svh */
// Testbench TLP helpers building request header beats and expected completion headers
`ifndef BRIDGE_TB_TLP_SVH
`define BRIDGE_TB_TLP_SVH

// Request header beat 0, DW0 in the low half
function automatic logic [63:0] req_hdr0(input logic [7:0] fmt_type, input logic [9:0] len,
        input logic [3:0] first_be, input logic ep, input logic [15:0] req_id,
        input logic [7:0] tag, input logic [2:0] tc, input logic [1:0] attr);
    logic [31:0] dw0;
    logic [31:0] dw1;
    logic [3:0]  last_be;
    last_be = (len > 1) ? 4'hf : 4'h0;
    dw0 = {fmt_type, 1'b0, tc, 4'h0, 1'b0, ep, attr, 2'b00, len};
    dw1 = {req_id, tag, last_be, first_be};
    return {dw1, dw0};
endfunction

// CplD header as {DW2, DW1, DW0}, fmt 010 type 01010
function automatic logic [95:0] cpl_hdr(input logic [15:0] cpl_id, input logic [15:0] req_id,
        input logic [7:0] tag, input logic [2:0] tc, input logic [1:0] attr,
        input logic [9:0] len, input logic [9:0] byte_addr);
    logic [31:0] dw0;
    logic [31:0] dw1;
    logic [31:0] dw2;
    dw0 = {8'h4a, 1'b0, tc, 4'h0, 1'b0, 1'b0, attr, 2'b00, len};
    // Successful status, byte count of four bytes per dword
    dw1 = {cpl_id, 3'b000, 1'b0, len, 2'b00};
    dw2 = {req_id, tag, 1'b0, byte_addr[6:0]};
    return {dw2, dw1, dw0};
endfunction

`endif

/* tb/bridge_tb.sv */
// Testbench for the PCIe to AL bridge with AL memory model and random back-pressure
`timescale 1ns/100ps

module bridge_tb import pcie_al_pkg::*; ();

    `include "bridge_tb_tlp.svh"

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_CPL} op_t;

    typedef struct packed {
        op_t         kind;
        logic [9:0]  addr;
        logic [7:0]  len;
        logic        poison;
        logic [3:0]  first_be;
        logic [31:0] base;
    } stim_t;

    typedef struct packed {
        logic [63:0] data;
        logic [1:0]  keep;
        logic        last;
    } tx_beat_t;

    localparam int          NUM_STIM    = 20;
    localparam int          STRESS_FROM = 13;
    localparam logic [15:0] CPL_ID      = 16'h0318;

    stim_t stim_tab [NUM_STIM] = '{
        '{OP_WR,  10'h010, 8'd1, 1'b0, 4'hf, 32'ha000_0100},
        '{OP_WR,  10'h020, 8'd2, 1'b0, 4'hf, 32'ha000_0200},
        '{OP_WR,  10'h040, 8'd3, 1'b0, 4'hf, 32'ha000_0300},
        '{OP_WR,  10'h080, 8'd8, 1'b0, 4'hf, 32'ha000_0400},
        '{OP_RD,  10'h010, 8'd1, 1'b0, 4'hf, 32'h0},
        '{OP_RD,  10'h020, 8'd2, 1'b0, 4'hf, 32'h0},
        '{OP_RD,  10'h084, 8'd5, 1'b0, 4'hf, 32'h0},
        '{OP_RD,  10'h080, 8'd8, 1'b0, 4'hf, 32'h0},
        // Dropped TLPs followed by a write that must land
        '{OP_WR,  10'h100, 8'd2, 1'b1, 4'hf, 32'hb000_0100},
        '{OP_WR,  10'h110, 8'd1, 1'b0, 4'h7, 32'hb000_0200},
        '{OP_CPL, 10'h120, 8'd2, 1'b0, 4'hf, 32'hb000_0300},
        '{OP_WR,  10'h130, 8'd2, 1'b0, 4'hf, 32'hb000_0400},
        '{OP_RD,  10'h100, 8'd2, 1'b0, 4'hf, 32'h0},
        // Alternating traffic under random ready
        '{OP_WR,  10'h200, 8'd4, 1'b0, 4'hf, 32'hc000_0100},
        '{OP_RD,  10'h200, 8'd4, 1'b0, 4'hf, 32'h0},
        '{OP_WR,  10'h300, 8'd6, 1'b0, 4'hf, 32'hc000_0200},
        '{OP_RD,  10'h2fc, 8'd7, 1'b0, 4'hf, 32'h0},
        '{OP_WR,  10'h3f0, 8'd3, 1'b0, 4'hf, 32'hc000_0300},
        '{OP_RD,  10'h3f0, 8'd3, 1'b0, 4'hf, 32'h0},
        '{OP_RD,  10'h130, 8'd2, 1'b0, 4'hf, 32'h0}
    };

    logic              clk;
    logic              rst_n;
    logic [AXIS_W-1:0] rx_tdata;
    logic [KEEP_W-1:0] rx_tkeep;
    logic              rx_tlast;
    logic              rx_tvalid;
    logic              rx_tready;
    logic [AXIS_W-1:0] tx_tdata;
    logic [KEEP_W-1:0] tx_tkeep;
    logic              tx_tlast;
    logic              tx_tvalid;
    logic              tx_tready;
    al_wr_t            al_wr;
    logic              al_wvalid;
    logic              al_wready;
    logic [ADDR_W-1:2] al_araddr;
    logic              al_arvalid;
    logic              al_arready;
    logic [AL_DW-1:0]  al_rdata;
    logic              al_rvalid;
    logic              al_rready;

    logic [31:0]       mem [256];
    logic [31:0]       ref_mem [256];
    logic [31:0]       rd_q [$];
    al_wr_t            exp_wr [$];
    logic [7:0]        exp_rd [$];
    tx_beat_t          exp_tx [$];
    logic              stress;
    logic              r_take;
    logic [63:0]       tx_seen;

    pcie_al_bridge UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .cfg_completer_id (CPL_ID),
        .rx_tdata         (rx_tdata),
        .rx_tkeep         (rx_tkeep),
        .rx_tlast         (rx_tlast),
        .rx_tvalid        (rx_tvalid),
        .rx_tready        (rx_tready),
        .tx_tdata         (tx_tdata),
        .tx_tkeep         (tx_tkeep),
        .tx_tlast         (tx_tlast),
        .tx_tvalid        (tx_tvalid),
        .tx_tready        (tx_tready),
        .al_wr            (al_wr),
        .al_wvalid        (al_wvalid),
        .al_wready        (al_wready),
        .al_araddr        (al_araddr),
        .al_arvalid       (al_arvalid),
        .al_arready       (al_arready),
        .al_rdata         (al_rdata),
        .al_rvalid        (al_rvalid),
        .al_rready        (al_rready)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {a ^ 8'hd0, ~a, a, a + 8'h11};
    endfunction

    task automatic report_error(input string msg);
        $display("ERR at %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_outputs_idle(input string when);
        assert (tx_tvalid === 1'b0 && al_wvalid === 1'b0 && al_arvalid === 1'b0 &&
                rx_tready === 1'b0)
        else report_error($sformatf("outputs active %s", when));
    endtask

    // Entered at posedge + 1 ns and left at posedge + 1 ns after the beat is taken
    task automatic send_beat(input logic [63:0] data, input logic [1:0] keep, input logic last);
        rx_tdata  = data;
        rx_tkeep  = keep;
        rx_tlast  = last;
        rx_tvalid = 1'b1;
        @(posedge clk);
        while (!rx_tready) begin
            @(posedge clk);
        end
        #1;
        rx_tvalid = 1'b0;
        if (stress && $urandom_range(3) == 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic queue_completion(input logic [95:0] hdr, input logic [7:0] w, input int len);
        tx_beat_t    b;
        logic [31:0] lo;
        int          i;
        for (i = 0; i < len; i++) begin
            exp_rd.push_back(w + 8'(i));
        end
        b = '{hdr[63:0], 2'b11, 1'b0};
        exp_tx.push_back(b);
        b = '{{ref_mem[w], hdr[95:64]}, 2'b11, len == 1};
        exp_tx.push_back(b);
        for (i = 1; i < len; i += 2) begin
            lo = ref_mem[w + 8'(i)];
            if (i + 1 < len) begin
                b = '{{ref_mem[w + 8'(i + 1)], lo}, 2'b11, i + 2 >= len};
            end else begin
                b = '{{32'h0, lo}, 2'b01, 1'b1};
            end
            exp_tx.push_back(b);
        end
    endtask

    task automatic apply_entry(input int idx);
        stim_t       s;
        logic [15:0] req_id;
        logic [7:0]  tag;
        logic [2:0]  tc;
        logic [1:0]  attr;
        logic [7:0]  fmt;
        logic [7:0]  w;
        int          i;
        s      = stim_tab[idx];
        stress = (idx >= STRESS_FROM);
        req_id = 16'($urandom);
        tag    = 8'(idx);
        tc     = 3'($urandom);
        attr   = 2'($urandom);
        w      = s.addr[9:2];
        case (s.kind)
            OP_WR:   fmt = 8'h40;
            OP_RD:   fmt = 8'h00;
            default: fmt = 8'h4a;
        endcase
        if (s.kind == OP_WR && !s.poison && s.first_be == 4'hf) begin
            for (i = 0; i < s.len; i++) begin
                exp_wr.push_back(al_wr_t'{w + 8'(i), s.base + i});
                ref_mem[w + 8'(i)] = s.base + i;
            end
        end
        if (s.kind == OP_RD) begin
            queue_completion(cpl_hdr(CPL_ID, req_id, tag, tc, attr, 10'(s.len), s.addr),
                             w, s.len);
        end
        send_beat(req_hdr0(fmt, 10'(s.len), s.first_be, s.poison, req_id, tag, tc, attr),
                  2'b11, 1'b0);
        if (s.kind == OP_RD) begin
            send_beat({32'h0, 22'h0, s.addr}, 2'b01, 1'b1);
        end else begin
            send_beat({s.base, 22'h0, s.addr}, 2'b11, s.len == 1);
            for (i = 1; i < s.len; i += 2) begin
                if (i + 1 < s.len) begin
                    send_beat({s.base + i + 1, s.base + i}, 2'b11, i + 2 >= s.len);
                end else begin
                    send_beat({32'h0, s.base + i}, 2'b01, 1'b1);
                end
            end
        end
    endtask

    // AL memory model answering each read one cycle after it is taken
    always begin
        @(posedge clk);
        r_take = al_rvalid && al_rready;
        if (rst_n && al_wvalid && al_wready) begin
            mem[al_wr.addr] = al_wr.data;
        end
        if (rst_n && al_arvalid && al_arready) begin
            rd_q.push_back(mem[al_araddr]);
        end
        #1;
        if (r_take) begin
            rd_q.delete(0);
        end
        al_wready  = !stress || ($urandom_range(3) != 0);
        al_arready = !stress || ($urandom_range(3) != 0);
        tx_tready  = !stress || ($urandom_range(3) != 0);
        if (!al_rvalid || r_take) begin
            al_rvalid = (rd_q.size() != 0) && (!stress || $urandom_range(3) != 0);
        end
        if (al_rvalid) begin
            al_rdata = rd_q[0];
        end
    end

    always @(posedge clk) begin
        if (rst_n && al_wvalid && al_wready) begin
            assert (exp_wr.size() != 0)
            else report_error($sformatf("unexpected AL write %h:%h", al_wr.addr, al_wr.data));
            assert (al_wr == exp_wr[0])
            else report_error($sformatf("AL write %h:%h, expected %h:%h", al_wr.addr,
                              al_wr.data, exp_wr[0].addr, exp_wr[0].data));
            exp_wr.delete(0);
        end
    end

    always @(posedge clk) begin
        if (rst_n && al_arvalid && al_arready) begin
            assert (exp_rd.size() != 0)
            else report_error($sformatf("unexpected AL read at %h", al_araddr));
            assert (al_araddr == exp_rd[0])
            else report_error($sformatf("AL read at %h, expected %h", al_araddr, exp_rd[0]));
            exp_rd.delete(0);
        end
    end

    // Upper half of a single-dword beat is not compared
    always @(posedge clk) begin
        if (rst_n && tx_tvalid && tx_tready) begin
            assert (exp_tx.size() != 0)
            else report_error("transmit beat with no completion pending");
            tx_seen = tx_tkeep[1] ? tx_tdata : {32'h0, tx_tdata[31:0]};
            assert (tx_seen == exp_tx[0].data && tx_tkeep == exp_tx[0].keep &&
                    tx_tlast == exp_tx[0].last)
            else report_error($sformatf("tx beat %h keep %b last %b, expected %h %b %b",
                              tx_seen, tx_tkeep, tx_tlast, exp_tx[0].data,
                              exp_tx[0].keep, exp_tx[0].last));
            exp_tx.delete(0);
        end
    end

    initial begin
        repeat (NUM_STIM * 200) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", NUM_STIM * 200);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(78));
        clk        = 1'b0;
        rst_n      = 1'b0;
        rx_tdata   = '0;
        rx_tkeep   = '0;
        rx_tlast   = 1'b0;
        rx_tvalid  = 1'b0;
        tx_tready  = 1'b0;
        al_wready  = 1'b0;
        al_arready = 1'b0;
        al_rvalid  = 1'b0;
        al_rdata   = '0;
        stress     = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i]     = fill_word(8'(i));
            ref_mem[i] = fill_word(8'(i));
        end
        repeat (4) begin
            @(posedge clk);
            #1;
            check_outputs_idle("during reset");
        end
        rst_n = 1'b1;
        @(posedge clk);
        check_outputs_idle("in the first cycle after reset");
        #1;
        for (int n = 0; n < NUM_STIM; n++) begin
            apply_entry(n);
        end
        while (exp_wr.size() != 0 || exp_tx.size() != 0 || al_arvalid || al_rvalid) begin
            @(posedge clk);
        end
        // Catch stray writes or beats
        repeat (20) @(posedge clk);
        assert (rd_q.size() == 0 && exp_rd.size() == 0 && !tx_tvalid && !al_wvalid) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            report_error("bridge still busy after the last completion");
        end
    end

endmodule
